// File: hw/crop_config.sv
// Vertical crop setup: permission from video settings, line offset and crop size
`timescale 1ns/1ns
`default_nettype none

module crop_config import frame_glue_pkg::*; (
    input  wire logic        clk_sys,
    input  wire logic        rst_n,
    input  wire status_t     status,
    input  wire video_mode_t video_mode,
    output crop_t            crop
);

    logic               crop_en;
    logic [vcopt_w-1:0] vcopt;
    logic [scale_w-1:0] crop_scale;
    logic [fx_w-1:0]    scan_fx;
    logic               ok_next;
    logic [crop_off_w-1:0] off_next;

    assign crop_en    = status[st_crop_en];
    assign vcopt      = status[st_vcopt_lo +: vcopt_w];
    assign crop_scale = status[st_scale_lo +: scale_w];
    assign scan_fx    = status[st_fx_lo +: fx_w];

    // Any scaler, FX or rotation setting rules the crop out
    assign ok_next = video_mode.hdmi_width == crop_width &&
                     video_mode.hdmi_height == crop_height &&
                     scan_fx == '0 &&
                     !video_mode.force_scan2x &&
                     crop_scale == '0 &&
                     !video_mode.direct_video &&
                     !video_mode.rotate_on;

    // Options 6..15 wrap to negative offsets
    always_comb begin
        if (vcopt < 4'd6) begin
            off_next = {vcopt, 1'b0};
        end else begin
            off_next = {vcopt, 1'b0} - 5'd24;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            crop <= '0;
        end else begin
            crop.crop_ok  <= ok_next;
            crop.crop_off <= off_next;
            // Uses last cycle's crop_ok, one clock behind
            crop.crop_size <= (crop.crop_ok && crop_en) ? crop_lines : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/ddr_arbiter.sv
// DDR arbiter: one port shared by the ROM loader and the screen rotator
`timescale 1ns/1ns
`default_nettype none

module ddr_arbiter import frame_glue_pkg::*; (
    input  wire logic     clk_sys,
    input  wire logic     rst_n,
    input  wire logic     downloading,
    input  wire ddr_req_t ld_req,
    input  wire ddr_req_t rot_req,
    input  wire logic     ddr_busy,
    output ddr_req_t      ddr_req,
    output logic          ld_busy,
    output logic          rot_busy
);

    logic     owner_ld;     // 1 when the loader owns the port
    ddr_req_t cur_req;
    logic     port_idle;

    assign cur_req = owner_ld ? ld_req : rot_req;

    // Safe to hand over: no transfer pending and DDR not stalling
    assign port_idle = !ddr_busy && !cur_req.rd && !cur_req.we;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            owner_ld <= 1'b0;   // Rotator owns the port out of reset
        end else if (port_idle) begin
            owner_ld <= downloading;
        end
    end

    assign ddr_req = cur_req;

    // The requester without the port sees a stalled bus
    always_comb begin
        if (owner_ld) begin
            ld_busy  = ddr_busy;
            rot_busy = 1'b1;
        end else begin
            ld_busy  = 1'b1;
            rot_busy = ddr_busy;
        end
    end

endmodule

`default_nettype wire

// File: hw/frame_glue_pkg.sv
// Frame glue shared definitions: OSD status fields, crop constants and bus structs
`default_nettype none

package frame_glue_pkg;

    // Field widths
    localparam int status_w    = 64;
    localparam int user_w      = 7;
    localparam int menumask_w  = 16;
    localparam int core_mod_w  = 7;
    localparam int hdmi_w      = 12;
    localparam int crop_off_w  = 5;
    localparam int crop_size_w = 12;
    localparam int vcopt_w     = 4;
    localparam int scale_w     = 2;
    localparam int fx_w        = 3;
    localparam int flip_w      = 2;
    localparam int burst_w     = 8;
    localparam int addr_w      = 29;
    localparam int be_w        = 8;

    // OSD status bit positions
    localparam int st_fx_lo    = 3;   // Scanline FX, 3 bits
    localparam int st_db15_en  = 37;
    localparam int st_uart_en  = 38;
    localparam int st_flip_lo  = 38;  // Rotate/flip option, shares bit 38 with UART enable
    localparam int st_crop_en  = 41;
    localparam int st_vcopt_lo = 42;  // Vertical crop option, 4 bits
    localparam int st_scale_lo = 46;  // Crop scale, 2 bits
    localparam int st_hsize_en = 48;

    typedef logic [status_w-1:0]   status_t;
    typedef logic [user_w-1:0]     user_port_t;
    typedef logic [menumask_w-1:0] menumask_t;  // A set bit hides the item

    typedef struct packed {
        logic [hdmi_w-1:0] hdmi_width;
        logic [hdmi_w-1:0] hdmi_height;
        logic              direct_video;
        logic              force_scan2x;
        logic              rotate_on;
    } video_mode_t;

    typedef struct packed {
        logic                   crop_ok;    // Display settings tolerate cropping
        logic [crop_off_w-1:0]  crop_off;   // Signed, -16..+15 lines
        logic [crop_size_w-1:0] crop_size;
    } crop_t;

    typedef struct packed {
        logic [burst_w-1:0] burstcnt;
        logic [addr_w-1:0]  addr;
        logic               rd;
        logic               we;
        logic [be_w-1:0]    be;
    } ddr_req_t;

    // Only a full HD output leaves room for the 216-line crop
    localparam logic [hdmi_w-1:0]      crop_width  = 12'd1920;
    localparam logic [hdmi_w-1:0]      crop_height = 12'd1080;
    localparam logic [crop_size_w-1:0] crop_lines  = 12'd216;

    localparam user_port_t user_idle = 7'h7f;

endpackage

`default_nettype wire

// File: hw/frame_glue_top.sv
// Frame glue top: user port, OSD mask, crop setup and DDR arbitration
`timescale 1ns/1ns
`default_nettype none

module frame_glue_top import frame_glue_pkg::*; (
    input  wire logic                  clk_sys,
    input  wire logic                  rst_n,
    input  wire status_t               status,
    input  wire video_mode_t           video_mode,
    input  wire logic [core_mod_w-1:0] core_mod,
    // User port
    input  wire user_port_t            user_in,
    input  wire user_port_t            joy_out,
    input  wire logic                  game_tx,
    input  wire logic                  uart_tx,
    output user_port_t                 user_out,
    output logic                       uart_rx,
    output logic                       db15_en,
    output logic                       uart_en,
    // OSD and crop
    output menumask_t                  menumask,
    output logic                       fb_flip,
    output crop_t                      crop,
    // DDR
    input  wire logic                  downloading,
    input  wire ddr_req_t              ld_req,
    input  wire ddr_req_t              rot_req,
    input  wire logic                  ddr_busy,
    output ddr_req_t                   ddr_req,
    output logic                       ld_busy,
    output logic                       rot_busy
);

    user_port_mux u_user_port_mux (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .status   ( status   ),
        .user_in  ( user_in  ),
        .joy_out  ( joy_out  ),
        .game_tx  ( game_tx  ),
        .uart_tx  ( uart_tx  ),
        .user_out ( user_out ),
        .uart_rx  ( uart_rx  ),
        .db15_en  ( db15_en  ),
        .uart_en  ( uart_en  )
    );

    osd_menu_mask u_osd_menu_mask (
        .clk_sys      ( clk_sys                 ),
        .rst_n        ( rst_n                   ),
        .status       ( status                  ),
        .direct_video ( video_mode.direct_video ),
        .core_mod     ( core_mod                ),
        .crop_ok      ( crop.crop_ok            ),  // Registered permission
        .menumask     ( menumask                ),
        .fb_flip      ( fb_flip                 )
    );

    crop_config u_crop_config (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .status     ( status     ),
        .video_mode ( video_mode ),
        .crop       ( crop       )
    );

    ddr_arbiter u_ddr_arbiter (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ld_req      ( ld_req      ),
        .rot_req     ( rot_req     ),
        .ddr_busy    ( ddr_busy    ),
        .ddr_req     ( ddr_req     ),
        .ld_busy     ( ld_busy     ),
        .rot_busy    ( rot_busy    )
    );

endmodule

`default_nettype wire

// File: hw/osd_menu_mask.sv
// OSD menu mask: hides entries that do not apply to the core, plus framebuffer flip
`timescale 1ns/1ns
`default_nettype none

module osd_menu_mask import frame_glue_pkg::*; (
    input  wire logic                  clk_sys,
    input  wire logic                  rst_n,
    input  wire status_t               status,
    input  wire logic                  direct_video,
    input  wire logic [core_mod_w-1:0] core_mod,
    input  wire logic                  crop_ok,
    output menumask_t                  menumask,
    output logic                       fb_flip
);

    logic vertical;
    logic hsize_en;

    assign vertical = core_mod[0];
    assign hsize_en = status[st_hsize_en];

    always_comb begin
        menumask    = '0;
        menumask[5] = crop_ok;      // Crop options
        menumask[4] = ~vertical;    // Rotate options only for vertical games
        menumask[2] = ~hsize_en;    // Horizontal scale settings
        menumask[1] = 1'b1;         // Always hidden with rotate options on
        menumask[0] = direct_video;
        // Bit 3 is the 60 Hz gate, not built here
    end

    // Flip request for the rotator framebuffer
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            fb_flip <= 1'b0;
        end else begin
            fb_flip <= status[st_flip_lo +: flip_w] == 2'd2;
        end
    end

endmodule

`default_nettype wire

// File: hw/user_port_mux.sv
// User port mux: shares the port between the DB15 adapter and the UART
`timescale 1ns/1ns
`default_nettype none

module user_port_mux import frame_glue_pkg::*; (
    input  wire logic       clk_sys,
    input  wire logic       rst_n,
    input  wire status_t    status,
    input  wire user_port_t user_in,
    input  wire user_port_t joy_out,
    input  wire logic       game_tx,
    input  wire logic       uart_tx,
    output user_port_t      user_out,
    output logic            uart_rx,
    output logic            db15_en,
    output logic            uart_en
);

    user_port_t uart_out;

    assign db15_en = status[st_db15_en];
    assign uart_en = status[st_uart_en];  // Used by the game or the cheat engine

    // Both transmitters talk on bit 0, upper pins held high
    assign uart_out = {{(user_w-1){1'b1}}, uart_tx & game_tx};

    // DB15 wins over the UART
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            user_out <= user_idle;
        end else if (db15_en) begin
            user_out <= joy_out;
        end else if (uart_en) begin
            user_out <= uart_out;
        end else begin
            user_out <= user_idle;
        end
    end

    // Receive line idles high when the UART is off
    assign uart_rx = uart_en ? user_in[1] : 1'b1;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the frame glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_frame_glue -f sources.f -o tb_frame_glue > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frame_glue > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sources.f
hw/frame_glue_pkg.sv
hw/user_port_mux.sv
hw/osd_menu_mask.sv
hw/crop_config.sv
hw/ddr_arbiter.sv
hw/frame_glue_top.sv
verification/frame_glue_sva.sv
verification/tb_frame_glue.sv

// File: verification/frame_glue_sva.sv
// DDR arbiter checks: owner stability under back-pressure, busy routing, reset owner
`timescale 1ns/1ns
`default_nettype none

module frame_glue_sva (
    input wire logic clk_sys,
    input wire logic rst_n,
    input wire logic ddr_busy,
    input wire logic owner_ld,
    input wire logic ld_busy,
    input wire logic rot_busy
);

    // No handover on a clock where the DDR stalls
    a_owner_held: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        ddr_busy |=> $stable(owner_ld)
    ) else $error("DDR owner changed while ddr_busy was high");

    a_nonowner_busy: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (owner_ld && rot_busy) || (!owner_ld && ld_busy)
    ) else $error("Requester without the DDR port did not see busy");

    // Rotator holds the port when reset lifts
    a_reset_owner: assert property (
        @(posedge clk_sys)
        $rose(rst_n) |-> !owner_ld
    ) else $error("Loader owned the DDR port right after reset");

endmodule

`default_nettype wire

// File: verification/tb_frame_glue.sv
// Frame glue testbench: table-driven user port, crop and OSD mask checks plus DDR handover
`timescale 1ns/1ns
`default_nettype none

module tb_frame_glue import frame_glue_pkg::*; ();

    typedef struct packed {
        status_t               status;
        video_mode_t           video_mode;
        logic [core_mod_w-1:0] core_mod;
        user_port_t            user_in;
        user_port_t            joy_out;
        logic                  game_tx;
        logic                  uart_tx;
        user_port_t            exp_user;
        logic                  exp_rx;
        menumask_t             exp_mask;
        crop_t                 exp_crop;
        logic                  exp_flip;
        logic [1:0]            exp_en;    // DB15 and UART enables
    } row_t;

    typedef struct packed {
        logic downloading;
        logic ddr_busy;
        logic ld_rd;          // Loader read strobe during the step
        logic exp_ld;         // Loader expected to own the port
        logic wait_handover;
    } ddr_step_t;

    logic                  clk_sys;
    logic                  rst_n;
    status_t               status;
    video_mode_t           video_mode;
    logic [core_mod_w-1:0] core_mod;
    user_port_t            user_in;
    user_port_t            joy_out;
    logic                  game_tx;
    logic                  uart_tx;
    user_port_t            user_out;
    logic                  uart_rx;
    logic                  db15_en;
    logic                  uart_en;
    menumask_t             menumask;
    logic                  fb_flip;
    crop_t                 crop;
    logic                  downloading;
    ddr_req_t              ld_req;
    ddr_req_t              rot_req;
    logic                  ddr_busy;
    ddr_req_t              ddr_req;
    logic                  ld_busy;
    logic                  rot_busy;

    row_t      rows[$];
    ddr_step_t steps[$];
    integer    seed;

    frame_glue_top u_frame_glue_top (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .video_mode  ( video_mode  ),
        .core_mod    ( core_mod    ),
        .user_in     ( user_in     ),
        .joy_out     ( joy_out     ),
        .game_tx     ( game_tx     ),
        .uart_tx     ( uart_tx     ),
        .user_out    ( user_out    ),
        .uart_rx     ( uart_rx     ),
        .db15_en     ( db15_en     ),
        .uart_en     ( uart_en     ),
        .menumask    ( menumask    ),
        .fb_flip     ( fb_flip     ),
        .crop        ( crop        ),
        .downloading ( downloading ),
        .ld_req      ( ld_req      ),
        .rot_req     ( rot_req     ),
        .ddr_busy    ( ddr_busy    ),
        .ddr_req     ( ddr_req     ),
        .ld_busy     ( ld_busy     ),
        .rot_busy    ( rot_busy    )
    );

    bind ddr_arbiter frame_glue_sva u_frame_glue_sva (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .ddr_busy ( ddr_busy ),
        .owner_ld ( owner_ld ),
        .ld_busy  ( ld_busy  ),
        .rot_busy ( rot_busy )
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_user_port(input user_port_t got, input user_port_t exp,
                                   input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_menumask(input menumask_t got, input menumask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: menumask is %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_crop(input crop_t got, input crop_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: crop is %0b/%0d/%0d, expected %0b/%0d/%0d",
                     $time, got.crop_ok, got.crop_off, got.crop_size,
                     exp.crop_ok, exp.crop_off, exp.crop_size);
            abort_run();
        end
    endtask

    task automatic check_ddr_req(input ddr_req_t got, input ddr_req_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: ddr_req is %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Flip field is bits 39:38, its low bit doubles as UART enable
    function automatic status_t build_status(input logic db15, input logic uart,
                                             input logic flip_hi, input logic crop_en,
                                             input logic [3:0] vcopt, input logic [1:0] scale,
                                             input logic hsize, input logic [2:0] fx);
        status_t s;
        s = '0;
        s[st_db15_en]       = db15;
        s[st_uart_en]       = uart;
        s[st_flip_lo + 1]   = flip_hi;
        s[st_crop_en]       = crop_en;
        s[st_vcopt_lo +: 4] = vcopt;
        s[st_scale_lo +: 2] = scale;
        s[st_hsize_en]      = hsize;
        s[st_fx_lo +: 3]    = fx;
        return s;
    endfunction

    function automatic video_mode_t mk_mode(input logic [11:0] w, input logic [11:0] h,
                                            input logic dv, input logic s2x, input logic rot);
        video_mode_t m;
        m.hdmi_width   = w;
        m.hdmi_height  = h;
        m.direct_video = dv;
        m.force_scan2x = s2x;
        m.rotate_on    = rot;
        return m;
    endfunction

    function automatic crop_t mk_crop(input logic ok, input logic [4:0] off,
                                      input logic [11:0] size);
        crop_t c;
        c.crop_ok   = ok;
        c.crop_off  = off;
        c.crop_size = size;
        return c;
    endfunction

    task automatic add_row(input status_t st, input video_mode_t vm, input logic [6:0] cm,
                           input user_port_t ui, input user_port_t jo, input logic gtx,
                           input logic utx, input user_port_t e_user, input logic e_rx,
                           input menumask_t e_mask, input crop_t e_crop, input logic e_flip,
                           input logic [1:0] e_en);
        row_t r;
        r = '{st, vm, cm, ui, jo, gtx, utx, e_user, e_rx, e_mask, e_crop, e_flip, e_en};
        rows.push_back(r);
    endtask

    task automatic build_tables();
        video_mode_t full_hd;
        full_hd = mk_mode(12'd1920, 12'd1080, 1'b0, 1'b0, 1'b0);
        // DB15 wins, crop allowed but not enabled
        add_row(build_status(1'b1, 1'b0, 1'b0, 1'b0, 4'd0, 2'd0, 1'b0, 3'd0), full_hd,
                7'h00, 7'h00, 7'h2a, 1'b1, 1'b1, 7'h2a, 1'b1, 16'h0036,
                mk_crop(1'b1, 5'd0, 12'd0), 1'b0, 2'b10);
        add_row(build_status(1'b1, 1'b1, 1'b0, 1'b1, 4'd5, 2'd0, 1'b1, 3'd0), full_hd,
                7'h01, 7'h00, 7'h15, 1'b1, 1'b1, 7'h15, 1'b0, 16'h0022,
                mk_crop(1'b1, 5'd10, 12'd216), 1'b0, 2'b11);
        // UART only, direct video blocks crop
        add_row(build_status(1'b0, 1'b1, 1'b0, 1'b1, 4'd6, 2'd0, 1'b0, 3'd0),
                mk_mode(12'd1920, 12'd1080, 1'b1, 1'b0, 1'b0),
                7'h00, 7'h02, 7'h00, 1'b0, 1'b1, 7'h7e, 1'b1, 16'h0017,
                mk_crop(1'b0, 5'd20, 12'd0), 1'b0, 2'b01);
        add_row(build_status(1'b0, 1'b1, 1'b1, 1'b1, 4'd15, 2'd0, 1'b0, 3'd1), full_hd,
                7'h41, 7'h7d, 7'h00, 1'b1, 1'b0, 7'h7e, 1'b0, 16'h0006,
                mk_crop(1'b0, 5'd6, 12'd0), 1'b0, 2'b01);
        // Idle port, flip field 2, scale set
        add_row(build_status(1'b0, 1'b0, 1'b1, 1'b1, 4'd0, 2'd1, 1'b1, 3'd0), full_hd,
                7'h00, 7'h00, 7'h55, 1'b1, 1'b1, 7'h7f, 1'b1, 16'h0012,
                mk_crop(1'b0, 5'd0, 12'd0), 1'b1, 2'b00);
        add_row(build_status(1'b0, 1'b0, 1'b0, 1'b1, 4'd3, 2'd0, 1'b0, 3'd0),
                mk_mode(12'd1280, 12'd1080, 1'b0, 1'b0, 1'b0),
                7'h00, 7'h00, 7'h00, 1'b0, 1'b0, 7'h7f, 1'b1, 16'h0016,
                mk_crop(1'b0, 5'd6, 12'd0), 1'b0, 2'b00);
        add_row(build_status(1'b0, 1'b0, 1'b0, 1'b1, 4'd3, 2'd0, 1'b0, 3'd0),
                mk_mode(12'd1920, 12'd1080, 1'b0, 1'b1, 1'b0),
                7'h00, 7'h00, 7'h00, 1'b0, 1'b0, 7'h7f, 1'b1, 16'h0016,
                mk_crop(1'b0, 5'd6, 12'd0), 1'b0, 2'b00);
        add_row(build_status(1'b1, 1'b0, 1'b1, 1'b1, 4'd0, 2'd0, 1'b0, 3'd0),
                mk_mode(12'd1920, 12'd1080, 1'b0, 1'b0, 1'b1),
                7'h00, 7'h00, 7'h01, 1'b0, 1'b0, 7'h01, 1'b1, 16'h0016,
                mk_crop(1'b0, 5'd0, 12'd0), 1'b1, 2'b10);
        add_row(build_status(1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 2'd0, 1'b0, 3'd0),
                mk_mode(12'd1920, 12'd720, 1'b0, 1'b0, 1'b0),
                7'h00, 7'h00, 7'h00, 1'b0, 1'b0, 7'h7f, 1'b1, 16'h0016,
                mk_crop(1'b0, 5'd0, 12'd0), 1'b0, 2'b00);
        add_row(build_status(1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 2'd0, 1'b0, 3'd0), full_hd,
                7'h00, 7'h00, 7'h00, 1'b0, 1'b0, 7'h7f, 1'b1, 16'h0036,
                mk_crop(1'b1, 5'd0, 12'd216), 1'b0, 2'b00);
        // DDR steps: downloading, ddr_busy, ld_rd, exp_ld, wait_handover
        steps.push_back(ddr_step_t'(5'b00000));
        steps.push_back(ddr_step_t'(5'b10011));
        steps.push_back(ddr_step_t'(5'b01010));  // Busy holds the loader
        steps.push_back(ddr_step_t'(5'b00110));  // Loader read pending
        steps.push_back(ddr_step_t'(5'b00001));
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_sys);
        #1;
        status     = r.status;
        video_mode = r.video_mode;
        core_mod   = r.core_mod;
        user_in    = r.user_in;
        joy_out    = r.joy_out;
        game_tx    = r.game_tx;
        uart_tx    = r.uart_tx;
        repeat (3) @(posedge clk_sys);
        #1;
        check_user_port(user_out, r.exp_user, "user_out");
        check_bit(uart_rx, r.exp_rx, "uart_rx");
        check_bit(db15_en, r.exp_en[1], "db15_en");
        check_bit(uart_en, r.exp_en[0], "uart_en");
        check_menumask(menumask, r.exp_mask);
        check_crop(crop, r.exp_crop);
        check_bit(fb_flip, r.exp_flip, "fb_flip");
    endtask

    task automatic randomize_reqs(input logic ld_rd);
        logic [31:0] rnd;
        rnd = $random(seed);
        ld_req.burstcnt = rnd[7:0];
        ld_req.be       = rnd[15:8];
        rot_req.burstcnt = rnd[23:16];
        rot_req.be       = rnd[31:24];
        rnd = $random(seed);
        ld_req.addr = rnd[28:0];
        rnd = $random(seed);
        rot_req.addr = rnd[28:0];
        ld_req.rd  = ld_rd;
        ld_req.we  = 1'b0;
        rot_req.rd = 1'b0;     // Rotator idle so it can give up the port
        rot_req.we = 1'b0;
    endtask

    // With ddr_busy low the busy pair shows the owner
    task automatic wait_for_owner(input logic exp_ld);
        int cycles;
        cycles = 0;
        while (exp_ld ? !(rot_busy && !ld_busy) : !(ld_busy && !rot_busy)) begin
            if (cycles >= 20) begin
                $display("Timeout: the DDR port was not handed to the %s within 20 clocks",
                         exp_ld ? "loader" : "rotator");
                abort_run();
            end
            @(posedge clk_sys);
            #1;
            cycles++;
        end
    endtask

    task automatic run_ddr_step(input ddr_step_t s);
        @(posedge clk_sys);
        #1;
        downloading = s.downloading;
        ddr_busy    = s.ddr_busy;
        randomize_reqs(s.ld_rd);
        if (s.wait_handover) begin
            wait_for_owner(s.exp_ld);
        end else begin
            repeat (3) @(posedge clk_sys);
            #1;
        end
        check_ddr_req(ddr_req, s.exp_ld ? ld_req : rot_req);
        check_bit(ld_busy, s.exp_ld ? ddr_busy : 1'b1, "ld_busy");
        check_bit(rot_busy, s.exp_ld ? 1'b1 : ddr_busy, "rot_busy");
    endtask

    initial begin
        int i;
        seed        = 32'h2f36196d;
        rst_n       = 1'b0;
        status      = '0;
        video_mode  = '0;
        core_mod    = '0;
        user_in     = '0;
        joy_out     = '0;
        game_tx     = 1'b0;
        uart_tx     = 1'b0;
        downloading = 1'b0;
        ddr_busy    = 1'b0;
        ld_req      = '0;
        rot_req     = '0;
        build_tables();
        repeat (5) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        for (i = 0; i < steps.size(); i++) begin
            run_ddr_step(steps[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
